// File: Bender.yml
package:
  name: cmpUnit

sources:
  - hw/cmpPkg.sv
  - hw/regFile.sv
  - hw/intCompare.sv
  - hw/fpCompare.sv
  - hw/cmpCtrl.sv
  - hw/cmpUnit.sv
  - target: test
    files:
      - testbench/cmpUnit_chk.sv
      - testbench/cmpUnitMon.sv
      - testbench/cmpUnitTb.sv

// File: filelist.f
hw/cmpPkg.sv
hw/regFile.sv
hw/intCompare.sv
hw/fpCompare.sv
hw/cmpCtrl.sv
hw/cmpUnit.sv
testbench/cmpUnit_chk.sv
testbench/cmpUnitMon.sv
testbench/cmpUnitTb.sv

// File: hw/cmpCtrl.sv
module cmpCtrl (
	input logic clk,
	input logic rstN,
	input logic issueValid,
	input cmpPkg::instr_t instr,
	input logic [cmpPkg::xlen-1:0] gprRdataA,
	input logic [cmpPkg::xlen-1:0] gprRdataB,
	input cmpPkg::condByte_t intCb,
	input cmpPkg::condByte_t fpCb,
	output logic [cmpPkg::gprAddrW-1:0] gprRaddrA,
	output logic [cmpPkg::gprAddrW-1:0] gprRaddrB,
	output logic [cmpPkg::xlen-1:0] opA,
	output logic [cmpPkg::xlen-1:0] opB,
	output logic isSigned,
	output logic crWe,
	output logic [cmpPkg::crAddrW-1:0] crWaddr,
	output cmpPkg::condByte_t crWdata,
	output logic resultValid,
	output logic [cmpPkg::crAddrW-1:0] resultCrd,
	output cmpPkg::condByte_t resultCb,
	output logic illegal
);

	// Decode results for the instruction in the issue cycle
	logic decLegal;
	cmpPkg::cmpKind_t decKind;
	logic [cmpPkg::xlen-1:0] decOpB;

	// Stage 1 state besides the operands
	logic s1Valid;
	logic [cmpPkg::crAddrW-1:0] s1Crd;
	cmpPkg::cmpKind_t s1Kind;

	// Condition byte chosen from the two comparators
	cmpPkg::condByte_t cbSel;

	// ====================
	// Issue cycle decode
	// ====================

	// The register fields sit at the same place in every form
	assign gprRaddrA = instr.r3.ra;
	assign gprRaddrB = instr.r3.rb;

	always_comb
	begin
		decLegal = 1'b0;
		decKind = cmpPkg::kindSigned;
		decOpB = gprRdataB;
		case (instr.r3.opcode)
			cmpPkg::opR3:
			begin
				case (instr.r3.func)
					cmpPkg::fnCmp:
					begin
						decLegal = 1'b1;
						decKind = cmpPkg::kindSigned;
					end
					cmpPkg::fnCmpu:
					begin
						decLegal = 1'b1;
						decKind = cmpPkg::kindUnsigned;
					end
					cmpPkg::fnFcmp:
					begin
						decLegal = 1'b1;
						decKind = cmpPkg::kindFloat;
					end
					default:
					begin
						decLegal = 1'b0;
					end
				endcase
			end
			// Signed immediate copies its top bit into the upper operand bits
			cmpPkg::opCmpi:
			begin
				decLegal = 1'b1;
				decKind = cmpPkg::kindSigned;
				decOpB = {{(cmpPkg::xlen-cmpPkg::immW){instr.ri.imm[cmpPkg::immW-1]}},
					instr.ri.imm};
			end
			// Unsigned immediate is padded with zeros
			cmpPkg::opCmpui:
			begin
				decLegal = 1'b1;
				decKind = cmpPkg::kindUnsigned;
				decOpB = {{(cmpPkg::xlen-cmpPkg::immW){1'b0}}, instr.ri.imm};
			end
			default:
			begin
				decLegal = 1'b0;
			end
		endcase
	end

	// ====================
	// Pipeline registers
	// ====================

	// Valid bits and the illegal pulse, one issue per cycle can be in each stage
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			s1Valid <= 1'b0;
			illegal <= 1'b0;
			resultValid <= 1'b0;
		end
		else
		begin
			s1Valid <= issueValid & decLegal;
			illegal <= issueValid & ~decLegal;
			resultValid <= s1Valid;
		end
	end

	// Operands and tags follow the valid bits without a reset
	always_ff @(posedge clk)
	begin
		if (issueValid)
		begin
			s1Crd <= instr.r3.crd;
			s1Kind <= decKind;
			opA <= gprRdataA;
			opB <= decOpB;
		end
		if (s1Valid)
		begin
			resultCrd <= s1Crd;
			resultCb <= cbSel;
		end
	end

	// The integer comparator needs to know how to read the top bits
	assign isSigned = (s1Kind == cmpPkg::kindSigned);

	// Float compares take the float byte and both integer kinds share the other
	assign cbSel = (s1Kind == cmpPkg::kindFloat) ? fpCb : intCb;

	// The condition register is written on the edge that loads stage 2
	assign crWe = s1Valid;
	assign crWaddr = s1Crd;
	assign crWdata = cbSel;

endmodule

// File: hw/cmpPkg.sv
package cmpPkg;

	// ====================
	// Sizes
	// ====================

	// Width of a general register and of every compare operand
	localparam int xlen = 64;

	// Register counts and the address widths that go with them
	localparam int numGpr = 32;
	localparam int numCr = 8;
	localparam int gprAddrW = 5;
	localparam int crAddrW = 3;

	// The register-immediate forms carry a 17 bit constant in the top bits
	localparam int immW = 17;

	// IEEE double layout below the sign bit
	localparam int dblExpW = 11;
	localparam int dblFracW = 52;

	// ====================
	// Instruction encoding
	// ====================

	// Major opcodes, anything else decodes as illegal
	localparam logic [6:0] opR3 = 7'h02;
	localparam logic [6:0] opCmpi = 7'h0A;
	localparam logic [6:0] opCmpui = 7'h0B;

	// Function codes that are valid under opR3
	localparam logic [2:0] fnCmp = 3'd0;
	localparam logic [2:0] fnCmpu = 3'd1;
	localparam logic [2:0] fnFcmp = 3'd2;

	// Register-register form, the top nine bits are not decoded
	typedef struct packed {
		logic [8:0] spare;
		logic [2:0] func;
		logic [gprAddrW-1:0] rb;
		logic [gprAddrW-1:0] ra;
		logic [crAddrW-1:0] crd;
		logic [6:0] opcode;
	} r3Fmt_t;

	// Register-immediate form, the immediate overlays rb and func
	typedef struct packed {
		logic [immW-1:0] imm;
		logic [gprAddrW-1:0] ra;
		logic [crAddrW-1:0] crd;
		logic [6:0] opcode;
	} riFmt_t;

	// Both views share opcode, crd and ra at the same bit positions
	typedef union packed {
		r3Fmt_t r3;
		riFmt_t ri;
	} instr_t;

	// ====================
	// Results
	// ====================

	// Condition byte written to the condition register file, un is the top bit
	typedef struct packed {
		logic un;
		logic ca;
		logic ge;
		logic gt;
		logic le;
		logic lt;
		logic ne;
		logic eq;
	} condByte_t;

	// Kind of comparison carried down the pipeline with the operands
	typedef enum logic [1:0] {
		kindSigned,
		kindUnsigned,
		kindFloat
	} cmpKind_t;

endpackage

// File: hw/cmpUnit.sv
module cmpUnit (
	input logic clk,
	input logic rstN,
	input logic issueValid,
	input cmpPkg::instr_t instr,
	input logic gprWe,
	input logic [cmpPkg::gprAddrW-1:0] gprWaddr,
	input logic [cmpPkg::xlen-1:0] gprWdata,
	input logic [cmpPkg::crAddrW-1:0] crRaddr,
	output cmpPkg::condByte_t crRdata,
	output logic resultValid,
	output logic [cmpPkg::crAddrW-1:0] resultCrd,
	output cmpPkg::condByte_t resultCb,
	output logic illegal
);

	// General register read path during the issue cycle
	logic [cmpPkg::gprAddrW-1:0] gprRaddrA;
	logic [cmpPkg::gprAddrW-1:0] gprRaddrB;
	logic [cmpPkg::xlen-1:0] gprRdataA;
	logic [cmpPkg::xlen-1:0] gprRdataB;

	// Stage 1 operands shared by both comparators
	logic [cmpPkg::xlen-1:0] opA;
	logic [cmpPkg::xlen-1:0] opB;
	logic isSigned;
	cmpPkg::condByte_t intCb;
	cmpPkg::condByte_t fpCb;

	// Condition register write from the end of stage 1
	logic crWe;
	logic [cmpPkg::crAddrW-1:0] crWaddr;
	cmpPkg::condByte_t crWdata;

	// ====================
	// Control and storage
	// ====================

	cmpCtrl uCtrl (
		.clk(clk),
		.rstN(rstN),
		.issueValid(issueValid),
		.instr(instr),
		.gprRdataA(gprRdataA),
		.gprRdataB(gprRdataB),
		.intCb(intCb),
		.fpCb(fpCb),
		.gprRaddrA(gprRaddrA),
		.gprRaddrB(gprRaddrB),
		.opA(opA),
		.opB(opB),
		.isSigned(isSigned),
		.crWe(crWe),
		.crWaddr(crWaddr),
		.crWdata(crWdata),
		.resultValid(resultValid),
		.resultCrd(resultCrd),
		.resultCb(resultCb),
		.illegal(illegal)
	);

	// General registers are loaded from outside and read by the control module
	regFile #(
		.payload_t(logic [cmpPkg::xlen-1:0]),
		.depth(cmpPkg::numGpr)
	) uGpr (
		.clk(clk),
		.rstN(rstN),
		.we(gprWe),
		.waddr(gprWaddr),
		.wdata(gprWdata),
		.raddrA(gprRaddrA),
		.raddrB(gprRaddrB),
		.rdataA(gprRdataA),
		.rdataB(gprRdataB)
	);

	// Condition registers have a single reader on port A
	regFile #(
		.payload_t(cmpPkg::condByte_t),
		.depth(cmpPkg::numCr)
	) uCr (
		.clk(clk),
		.rstN(rstN),
		.we(crWe),
		.waddr(crWaddr),
		.wdata(crWdata),
		.raddrA(crRaddr),
		.raddrB('0),
		.rdataA(crRdata),
		.rdataB()
	);

	// ====================
	// Comparators
	// ====================

	intCompare uIntCmp (
		.isSigned(isSigned),
		.a(opA),
		.b(opB),
		.cb(intCb)
	);

	fpCompare uFpCmp (
		.a(opA),
		.b(opB),
		.cb(fpCb)
	);

endmodule

// File: hw/fpCompare.sv
module fpCompare (
	input logic [cmpPkg::xlen-1:0] a,
	input logic [cmpPkg::xlen-1:0] b,
	output cmpPkg::condByte_t cb
);

	// Decoded fields of both doubles
	logic signA;
	logic signB;
	logic [cmpPkg::dblExpW-1:0] expA;
	logic [cmpPkg::dblExpW-1:0] expB;
	logic [cmpPkg::dblFracW-1:0] fracA;
	logic [cmpPkg::dblFracW-1:0] fracB;

	// Magnitude is everything below the sign bit
	logic [cmpPkg::xlen-2:0] magA;
	logic [cmpPkg::xlen-2:0] magB;

	// Classification of each operand
	logic nanA;
	logic nanB;
	logic infA;
	logic infB;
	logic bothZero;
	logic unord;

	// Ordering of two ordered values
	logic isEq;
	logic isLt;

	assign signA = a[cmpPkg::xlen-1];
	assign signB = b[cmpPkg::xlen-1];
	assign expA = a[cmpPkg::xlen-2 -: cmpPkg::dblExpW];
	assign expB = b[cmpPkg::xlen-2 -: cmpPkg::dblExpW];
	assign fracA = a[cmpPkg::dblFracW-1:0];
	assign fracB = b[cmpPkg::dblFracW-1:0];
	assign magA = a[cmpPkg::xlen-2:0];
	assign magB = b[cmpPkg::xlen-2:0];

	// An all-ones exponent is NaN with a nonzero fraction and infinity otherwise
	assign nanA = (&expA) && (fracA != '0);
	assign nanB = (&expB) && (fracB != '0);
	assign infA = (&expA) && (fracA == '0);
	assign infB = (&expB) && (fracB == '0);
	assign unord = nanA | nanB;

	// Plus and minus zero differ only in the sign bit
	assign bothZero = (magA == '0) && (magB == '0);

	// Identical bit patterns are equal once NaN is ruled out
	assign isEq = bothZero || (a == b);

	// ====================
	// Sign and magnitude order
	// ====================

	always_comb
	begin
		if (bothZero)
			isLt = 1'b0;
		// Opposite signs, the negative operand is the smaller one
		else if (signA != signB)
			isLt = signA;
		// Both positive, a larger magnitude is a larger value
		else if (!signA)
			isLt = magA < magB;
		// Both negative, a larger magnitude is a smaller value
		else
			isLt = magA > magB;
	end

	// Assemble the byte, an unordered compare clears every ordering flag
	always_comb
	begin
		cb = '0;
		cb.un = unord;
		cb.ca = infA | infB;
		cb.eq = ~unord & isEq;
		cb.ne = unord | ~isEq;
		cb.lt = ~unord & isLt;
		cb.le = ~unord & (isLt | isEq);
		cb.gt = ~unord & ~isLt & ~isEq;
		cb.ge = ~unord & ~isLt;
	end

endmodule

// File: hw/intCompare.sv
module intCompare (
	input logic isSigned,
	input logic [cmpPkg::xlen-1:0] a,
	input logic [cmpPkg::xlen-1:0] b,
	output cmpPkg::condByte_t cb
);

	// One bit wider difference, the top bit is the borrow out of a minus b
	logic [cmpPkg::xlen:0] diff;

	// Ordering flags for each interpretation of the operands
	logic ltSigned;
	logic ltUnsigned;
	logic isEq;
	logic isLt;

	// Zero extend both operands so the extra bit catches the borrow
	assign diff = {1'b0, a} - {1'b0, b};

	// Signed order reads the top bits as sign bits
	assign ltSigned = $signed(a) < $signed(b);

	// Unsigned order is the borrow itself
	assign ltUnsigned = diff[cmpPkg::xlen];

	// Equality is the same for both kinds
	assign isEq = (a == b);

	// Pick the ordering that the instruction asked for
	assign isLt = isSigned ? ltSigned : ltUnsigned;

	// ====================
	// Condition byte
	// ====================

	always_comb
	begin
		cb = '0;
		// Integer operands are always ordered
		cb.un = 1'b0;
		// Carry reports the raw borrow whatever the signedness
		cb.ca = diff[cmpPkg::xlen];
		cb.eq = isEq;
		cb.ne = ~isEq;
		cb.lt = isLt;
		// Less or equal folds in the equal case
		cb.le = isLt | isEq;
		// Greater is what remains when neither less nor equal holds
		cb.gt = ~isLt & ~isEq;
		cb.ge = ~isLt;
	end

endmodule

// File: hw/regFile.sv
module regFile #(
	parameter type payload_t = logic [63:0],
	parameter int depth = 32
) (
	input logic clk,
	input logic rstN,
	input logic we,
	input logic [$clog2(depth)-1:0] waddr,
	input payload_t wdata,
	input logic [$clog2(depth)-1:0] raddrA,
	input logic [$clog2(depth)-1:0] raddrB,
	output payload_t rdataA,
	output payload_t rdataB
);

	// Storage for every entry, one payload per address
	payload_t mem [depth];

	// ====================
	// Write port
	// ====================

	// Reset zeroes every entry so reads after reset return a known value
	// A write lands on the clock edge and is visible to reads from the next cycle
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			mem <= '{default: '0};
		end
		else if (we)
		begin
			mem[waddr] <= wdata;
		end
	end

	// ====================
	// Read ports
	// ====================

	// Both reads are plain combinational lookups with no bypass of a same-cycle write
	assign rdataA = mem[raddrA];

	// Second port for the rb operand of a register-register compare
	assign rdataB = mem[raddrB];

endmodule

// File: testbench/cmpUnitMon.sv
module cmpUnitMon (
	input logic clk,
	input logic rstN,
	input logic issueValid,
	input logic [31:0] instr,
	input logic gprWe,
	input logic [4:0] gprWaddr,
	input logic [63:0] gprWdata,
	input logic [2:0] crRaddr,
	input logic [7:0] crRdata,
	input logic resultValid,
	input logic [2:0] resultCrd,
	input logic [7:0] resultCb,
	input logic illegal,
	input logic tblExpValid,
	input logic [7:0] tblExp
);

	timeunit 1ns;
	timeprecision 1ps;

	// Shadow state and the predictions still in flight
	logic [63:0] shadowGpr [32];
	logic [7:0] shadowCr [8];
	logic [7:0] expCbQ [$];
	logic [2:0] expCrdQ [$];
	int expCycQ [$];
	int cycle;
	int passCount;
	int failCount;
	int testNum;
	int pending;
	logic illExp;

	// Byte layout from bit 7 down is un ca ge gt le lt ne eq
	// Kind 0 is signed, 1 is unsigned and 2 is float
	function automatic logic [7:0] predict(input int kind, input logic [63:0] a,
		input logic [63:0] b);
		logic lt;
		logic eq;
		logic nan;
		logic inf;
		real ra;
		real rb;
		nan = (a[62:52] == 11'h7FF && a[51:0] != 0) || (b[62:52] == 11'h7FF && b[51:0] != 0);
		inf = (a[62:0] == 63'h7FF0_0000_0000_0000) || (b[62:0] == 63'h7FF0_0000_0000_0000);
		if (kind == 2)
		begin
			if (nan)
				return {1'b1, inf, 6'b000010};
			ra = $bitstoreal(a);
			rb = $bitstoreal(b);
			lt = ra < rb;
			eq = ra == rb;
			return {1'b0, inf, !lt, !lt && !eq, lt || eq, lt, !eq, eq};
		end
		lt = (kind == 0) ? ($signed(a) < $signed(b)) : (a < b);
		eq = a == b;
		return {1'b0, a < b, !lt, !lt && !eq, lt || eq, lt, !eq, eq};
	endfunction

	always @(posedge clk or negedge rstN)
	begin : watch
		logic [7:0] expCb;
		logic [63:0] opB;
		logic [2:0] crd;
		logic legal;
		int kind;
		int issued;
		if (!rstN)
		begin
			shadowGpr = '{default: '0};
			shadowCr = '{default: '0};
			illExp = 1'b0;
			cycle = 0;
		end
		else
		begin
			// Illegal pulse belongs to the issue seen on the previous edge
			if (illegal !== illExp)
			begin
				$display("ERROR %0t illegal expected %0b actual %0b", $time, illExp, illegal);
				failCount++;
			end
			else if (illExp)
			begin
				testNum++;
				passCount++;
				$display("test %0d illegal instruction PASS", testNum);
			end
			if (resultValid && expCbQ.size() == 0)
			begin
				$display("A result came out with no compare in flight");
				failCount++;
			end
			else if (resultValid)
			begin
				testNum++;
				expCb = expCbQ.pop_front();
				crd = expCrdQ.pop_front();
				issued = expCycQ.pop_front();
				shadowCr[crd] = expCb;
				if (cycle != issued + 2)
					$display("Result of test %0d arrived %0d cycles after issue", testNum,
						cycle - issued);
				if (resultCrd !== crd)
					$display("ERROR %0t resultCrd expected %0d actual %0d", $time, crd, resultCrd);
				if (resultCb !== expCb)
					$display("ERROR %0t resultCb expected %02h actual %02h", $time, expCb, resultCb);
				if (cycle == issued + 2 && resultCrd === crd && resultCb === expCb)
				begin
					passCount++;
					$display("test %0d crd %0d cb %02h PASS", testNum, crd, expCb);
				end
				else
				begin
					failCount++;
					$display("test %0d crd %0d cb %02h FAIL", testNum, crd, expCb);
				end
			end
			// Every cycle the addressed condition register must match the shadow
			if (crRdata !== shadowCr[crRaddr])
			begin
				$display("ERROR %0t crRdata expected %02h actual %02h", $time,
					shadowCr[crRaddr], crRdata);
				failCount++;
			end
			// Predict from the registers as they stood before this edge
			illExp = 1'b0;
			if (issueValid)
			begin
				legal = 1'b1;
				kind = 0;
				opB = shadowGpr[instr[19:15]];
				if (instr[6:0] == 7'h02 && instr[22:20] <= 3'd2)
					kind = instr[22:20];
				else if (instr[6:0] == 7'h0A)
					opB = {{47{instr[31]}}, instr[31:15]};
				else if (instr[6:0] == 7'h0B)
				begin
					kind = 1;
					opB = {47'b0, instr[31:15]};
				end
				else
					legal = 1'b0;
				illExp = !legal;
				if (legal)
				begin
					expCb = predict(kind, shadowGpr[instr[14:10]], opB);
					expCbQ.push_back(tblExpValid ? tblExp : expCb);
					expCrdQ.push_back(instr[9:7]);
					expCycQ.push_back(cycle);
				end
			end
			if (gprWe)
				shadowGpr[gprWaddr] = gprWdata;
			cycle++;
		end
		pending = expCbQ.size() + illExp;
	end

endmodule

// File: testbench/cmpUnitTb.sv
module cmpUnitTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int numRows = 14;

	logic clk = 1'b0;
	logic rstN = 1'b0;
	logic issueValid = 1'b0;
	logic [31:0] instr = '0;
	logic gprWe = 1'b0;
	logic [4:0] gprWaddr = '0;
	logic [63:0] gprWdata = '0;
	logic [2:0] crRaddr = '0;
	logic [7:0] crRdata;
	logic resultValid;
	logic [2:0] resultCrd;
	logic [7:0] resultCb;
	logic illegal;
	logic tblExpValid = 1'b0;
	logic [7:0] tblExp = '0;
	logic [31:0] lfsr = 32'h38ca_fa09;
	logic timedOut = 1'b0;

	// Directed rows, register operands sit in distinct GPRs per row
	logic [6:0] tOp [numRows];
	logic [2:0] tFn [numRows];
	logic [4:0] tRa [numRows];
	logic [4:0] tRb [numRows];
	logic [16:0] tImm [numRows];
	logic [63:0] tA [numRows];
	logic [63:0] tB [numRows];
	logic [7:0] tExp [numRows];

	always #2 clk = ~clk;

	// Sweep the readback address so every condition register gets checked
	always @(posedge clk)
		crRaddr <= crRaddr + 3'd1;

	cmpUnit i_dut (.clk(clk), .rstN(rstN), .issueValid(issueValid), .instr(instr),
		.gprWe(gprWe), .gprWaddr(gprWaddr), .gprWdata(gprWdata), .crRaddr(crRaddr),
		.crRdata(crRdata), .resultValid(resultValid), .resultCrd(resultCrd),
		.resultCb(resultCb), .illegal(illegal));

	cmpUnitMon i_mon (.clk(clk), .rstN(rstN), .issueValid(issueValid), .instr(instr),
		.gprWe(gprWe), .gprWaddr(gprWaddr), .gprWdata(gprWdata), .crRaddr(crRaddr),
		.crRdata(crRdata), .resultValid(resultValid), .resultCrd(resultCrd),
		.resultCb(resultCb), .illegal(illegal), .tblExpValid(tblExpValid), .tblExp(tblExp));

	// Galois LFSR, one step per bit taken
	function automatic logic [63:0] takeBits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic writeGpr(input logic [4:0] addr, input logic [63:0] data);
		@(posedge clk);
		gprWe <= 1'b1;
		gprWaddr <= addr;
		gprWdata <= data;
	endtask

	task automatic setRow(input int i, input logic [6:0] op, input logic [2:0] fn,
		input logic [4:0] ra, input logic [4:0] rb, input logic [16:0] imm,
		input logic [63:0] a, input logic [63:0] b, input logic [7:0] exp);
		tOp[i] = op;
		tFn[i] = fn;
		tRa[i] = ra;
		tRb[i] = rb;
		tImm[i] = imm;
		tA[i] = a;
		tB[i] = b;
		tExp[i] = exp;
	endtask

	initial
	begin : stimulus
		logic [63:0] r;
		logic [6:0] op;
		int n;
		// ====================
		// Directed table
		// ====================
		setRow(0, 7'h02, 3'd0, 1, 2, 0, -64'sd5, 64'd3, 8'h0E);
		setRow(1, 7'h02, 3'd0, 3, 4, 0, 64'd7, 64'd7, 8'h29);
		setRow(2, 7'h02, 3'd0, 5, 6, 0, 64'd3, -64'sd5, 8'h72);
		setRow(3, 7'h02, 3'd1, 1, 2, 0, -64'sd5, 64'd3, 8'h32);
		setRow(4, 7'h02, 3'd1, 5, 6, 0, 64'd3, -64'sd5, 8'h4E);
		setRow(5, 7'h0A, 3'd0, 7, 0, 17'h1FFFF, -64'sd2, 0, 8'h4E);
		setRow(6, 7'h0B, 3'd0, 7, 0, 17'h1FFFF, -64'sd2, 0, 8'h32);
		setRow(7, 7'h02, 3'd2, 8, 9, 0, 64'h3FF0_0000_0000_0000, 64'h4000_0000_0000_0000, 8'h0E);
		setRow(8, 7'h02, 3'd2, 10, 11, 0, 64'h4004_0000_0000_0000, 64'hC008_0000_0000_0000, 8'h32);
		setRow(9, 7'h02, 3'd2, 12, 13, 0, 64'h0, 64'h8000_0000_0000_0000, 8'h29);
		setRow(10, 7'h02, 3'd2, 14, 8, 0, 64'h7FF8_0000_0000_0000, 64'h3FF0_0000_0000_0000, 8'h82);
		setRow(11, 7'h02, 3'd2, 15, 8, 0, 64'h7FF0_0000_0000_0000, 64'h3FF0_0000_0000_0000, 8'h72);
		setRow(12, 7'h02, 3'd2, 16, 16, 0, 64'hFFF0_0000_0000_0000, 64'hFFF0_0000_0000_0000, 8'h69);
		setRow(13, 7'h02, 3'd5, 1, 2, 0, -64'sd5, 64'd3, 8'h00);
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		for (int i = 0; i < numRows; i++)
		begin
			writeGpr(tRa[i], tA[i]);
			if (tOp[i] == 7'h02)
				writeGpr(tRb[i], tB[i]);
		end
		@(posedge clk);
		gprWe <= 1'b0;
		// Rows go out back to back, plus one unknown opcode at the end
		for (int i = 0; i <= numRows; i++)
		begin
			@(posedge clk);
			issueValid <= 1'b1;
			tblExpValid <= (i < numRows);
			if (i == numRows)
				instr <= {22'b0, 3'd2, 7'h05};
			else if (tOp[i] == 7'h02)
				instr <= {9'b0, tFn[i], tRb[i], tRa[i], i[2:0], tOp[i]};
			else
				instr <= {tImm[i], tRa[i], i[2:0], tOp[i]};
			tblExp <= (i < numRows) ? tExp[i] : 8'h00;
		end
		@(posedge clk);
		issueValid <= 1'b0;
		tblExpValid <= 1'b0;
		// ====================
		// Random phase
		// ====================
		for (int i = 0; i < 32; i++)
		begin
			r = takeBits(64);
			writeGpr(i[4:0], r);
		end
		@(posedge clk);
		gprWe <= 1'b0;
		n = 0;
		while (n < 200)
		begin
			@(posedge clk);
			r = takeBits(1);
			issueValid <= r[0];
			if (r[0])
			begin
				r = takeBits(3);
				op = (r[2:0] == 3'd2) ? 7'h0A : (r[2:0] == 3'd3) ? 7'h0B :
					(r[2:0] == 3'd7) ? 7'h7F : 7'h02;
				instr[6:0] <= op;
				r = takeBits(2);
				instr[22:20] <= {1'b0, r[1:0]};
				r = takeBits(22);
				instr[31:23] <= r[21:13];
				instr[19:7] <= r[12:0];
				n++;
			end
		end
		@(posedge clk);
		issueValid <= 1'b0;
		// Drain whatever is still in flight, looking between edges where the monitor is settled
		n = 0;
		@(negedge clk);
		while (i_mon.pending != 0 && n < 50)
		begin
			@(negedge clk);
			n++;
		end
		if (i_mon.pending != 0)
		begin
			timedOut = 1'b1;
			$display("Timed out waiting for %0d results to drain", i_mon.pending);
		end
		repeat (2) @(negedge clk);
		$display("Summary: %0d passed, %0d failed, %0d assertion failures", i_mon.passCount,
			i_mon.failCount, i_dut.uCtrl.uChk.assertFails);
		if (i_mon.failCount == 0 && i_dut.uCtrl.uChk.assertFails == 0 &&
			i_mon.passCount > 0 && !timedOut)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: testbench/cmpUnit_chk.sv
module cmpUnit_chk (
	input logic clk,
	input logic rstN,
	input logic issueValid,
	input logic [31:0] instr,
	input logic resultValid,
	input logic illegal,
	input logic crWe
);

	timeunit 1ns;
	timeprecision 1ps;

	// Number of assertion failures seen so far
	int assertFails = 0;

	// Legal forms decoded from the raw word, apart from the decoder in the control module
	logic legalIssue;

	assign legalIssue = (instr[6:0] == cmpPkg::opR3 && instr[22:20] <= cmpPkg::fnFcmp) ||
		(instr[6:0] == cmpPkg::opCmpi) || (instr[6:0] == cmpPkg::opCmpui);

	// Both output pulses stay quiet while reset is held
	assert property (@(posedge clk) !rstN |=> (!resultValid && !illegal))
	else
	begin
		$error("output pulse during reset");
		assertFails++;
	end

	// A legal issue always reaches the result port on the second edge
	assert property (@(posedge clk) disable iff (!rstN)
		(issueValid && legalIssue) |-> ##2 resultValid)
	else
	begin
		$error("result missing two edges after a legal issue");
		assertFails++;
	end

	// An illegal instruction pulses illegal, writes no condition register and gives no result
	assert property (@(posedge clk) disable iff (!rstN)
		(issueValid && !legalIssue) |=> (illegal && !crWe) ##1 !resultValid)
	else
	begin
		$error("illegal instruction not rejected cleanly");
		assertFails++;
	end

endmodule

bind cmpCtrl cmpUnit_chk uChk (
	.clk(clk),
	.rstN(rstN),
	.issueValid(issueValid),
	.instr(instr),
	.resultValid(resultValid),
	.illegal(illegal),
	.crWe(crWe)
);
